/* project.f */
+incdir+include
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_exec_unit.sv
source/rv_core_slice.sv
test/rv_core_slice_tb.sv

/* Bender.yml */
package:
  name: rv_core_slice

export_include_dirs:
  - include

sources:
  - files:
      - source/rv_isa_pkg.sv
      - source/rv_pipe_pkg.sv
      - source/rv_decode.sv
      - source/rv_regfile.sv
      - source/rv_alu.sv
      - source/rv_exec_unit.sv
      - source/rv_core_slice.sv
  - target: test
    files:
      - test/rv_core_slice_tb.sv

/* test/rv_core_slice_tb.sv */
// testbench for rv_core_slice with clock, stimulus, reference model and compare tasks
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core_slice_tb
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
();

  logic    clk;
  logic    reset;
  logic    fetch_valid;
  fetch_t  fetch;
  logic    retire_valid;
  retire_t retire;

  integer           seed;
  int               cycle;
  int               k;
  logic [31:0]      word;
  logic [4:0]       prev_rd;
  logic [4:0]       next_rd;
  logic [63:0]      pc_cnt;
  string            test_name;
  logic [63:0]      shadow_regs [32];   // architectural state seen by the model
  retire_t          exp_q [$];          // expected records in issue order
  int               due_q [$];          // cycle each record must retire in
  retire_t          exp_ret;
  int               exp_due;

  rv_core_slice dut_i (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch        (fetch),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial cycle = 0;
  always @(posedge clk) cycle <= cycle + 1;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [63:0] exp, input logic [63:0] act);
    $display("** Error [%s] %s: expected %h, actual %h", name, field, exp, act);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_mem(input string name, input mem_req_t exp, input mem_req_t act);
    if (act.valid !== exp.valid) report_mismatch(name, "mem.valid", exp.valid, act.valid);
    if (exp.valid) begin
      if (act.write !== exp.write) report_mismatch(name, "mem.write", exp.write, act.write);
      if (act.addr !== exp.addr) report_mismatch(name, "mem.addr", exp.addr, act.addr);
      if (act.size !== exp.size) report_mismatch(name, "mem.size", exp.size, act.size);
      if (act.unsigned_load !== exp.unsigned_load)
        report_mismatch(name, "mem.unsigned_load", exp.unsigned_load, act.unsigned_load);
      if (exp.write && (act.wdata !== exp.wdata))
        report_mismatch(name, "mem.wdata", exp.wdata, act.wdata);
    end
  endtask

  task automatic check_retire(input string name, input retire_t exp, input retire_t act);
    if (act.pc !== exp.pc) report_mismatch(name, "pc", exp.pc, act.pc);
    if (act.op !== exp.op) report_mismatch(name, "op", exp.op, act.op);
    if (act.rd !== exp.rd) report_mismatch(name, "rd", exp.rd, act.rd);
    if (act.we !== exp.we) report_mismatch(name, "we", exp.we, act.we);
    if (exp.we && (act.wdata !== exp.wdata)) report_mismatch(name, "wdata", exp.wdata, act.wdata);
    if (act.next_pc !== exp.next_pc) report_mismatch(name, "next_pc", exp.next_pc, act.next_pc);
    if (act.ebreak !== exp.ebreak) report_mismatch(name, "ebreak", exp.ebreak, act.ebreak);
    if (act.illegal !== exp.illegal) report_mismatch(name, "illegal", exp.illegal, act.illegal);
    check_mem(name, exp.mem, act.mem);
  endtask

  function automatic logic [63:0] sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  // expected retire record straight from the isa rules
  function automatic retire_t model_retire(input fetch_t f);
    retire_t     r;
    logic [31:0] i;
    logic [2:0]  f3;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    i = f.inst;
    f3 = i[14:12];
    a = shadow_regs[i[19:15]];
    b = shadow_regs[i[24:20]];
    imm_i = {{52{i[31]}}, i[31:20]};
    imm_s = {{52{i[31]}}, i[31:25], i[11:7]};
    imm_b = {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
    imm_u = {{32{i[31]}}, i[31:12], 12'h000};
    imm_j = {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
    r = '0;
    r.pc = f.pc;
    r.rd = i[11:7];
    r.op = OP_ILLEGAL;
    r.next_pc = f.pc + 64'd4;
    case (i[6:0])
      MAJ_LUI:       r.op = OP_LUI;
      MAJ_AUIPC:     r.op = OP_AUIPC;
      MAJ_JAL:       r.op = OP_JAL;
      MAJ_JALR:      if (f3 == 3'b000) r.op = OP_JALR;
      MAJ_BRANCH:    r.op = (f3 == 3'b001) ? OP_BNE : (f3 == 3'b101) ? OP_BGE : OP_ILLEGAL;
      MAJ_LOAD: begin
        case (f3)
          3'b010:  r.op = OP_LW;
          3'b100:  r.op = OP_LBU;
          3'b011:  r.op = OP_LD;
          default: r.op = OP_ILLEGAL;
        endcase
      end
      MAJ_STORE: begin
        case (f3)
          3'b000:  r.op = OP_SB;
          3'b001:  r.op = OP_SH;
          3'b010:  r.op = OP_SW;
          3'b011:  r.op = OP_SD;
          default: r.op = OP_ILLEGAL;
        endcase
      end
      MAJ_OP_IMM: begin
        case (f3)
          3'b000:  r.op = OP_ADDI;
          3'b011:  r.op = OP_SLTIU;
          3'b100:  r.op = OP_XORI;
          3'b111:  r.op = OP_ANDI;
          3'b001:  if (i[31:26] == 6'b000000) r.op = OP_SLLI;
          3'b101:  r.op = (i[31:26] == 6'b000000) ? OP_SRLI :
                          (i[31:26] == 6'b010000) ? OP_SRAI : OP_ILLEGAL;
          default: r.op = OP_ILLEGAL;
        endcase
      end
      MAJ_OP_IMM_32: if (f3 == 3'b000) r.op = OP_ADDIW;
      MAJ_OP: begin
        case ({i[31:25], f3})
          10'b0000000_000: r.op = OP_ADD;
          10'b0100000_000: r.op = OP_SUB;
          10'b0000000_011: r.op = OP_SLTU;
          10'b0000000_110: r.op = OP_OR;
          10'b0000000_111: r.op = OP_AND;
          default:         r.op = OP_ILLEGAL;
        endcase
      end
      MAJ_OP_32: begin
        case ({i[31:25], f3})
          10'b0000000_000: r.op = OP_ADDW;
          10'b0000000_001: r.op = OP_SLLW;
          10'b0000001_000: r.op = OP_MULW;
          default:         r.op = OP_ILLEGAL;
        endcase
      end
      MAJ_SYSTEM: if (i == `EBREAK_INST) r.op = OP_EBREAK;
      default: r.op = OP_ILLEGAL;
    endcase
    case (r.op)
      OP_LUI:          r.wdata = imm_u;
      OP_AUIPC:        r.wdata = f.pc + imm_u;
      OP_JAL, OP_JALR: r.wdata = f.pc + 64'd4;   // link
      OP_ADDI:         r.wdata = a + imm_i;
      OP_SLTIU:        r.wdata = (a < imm_i) ? 64'd1 : 64'd0;
      OP_XORI:         r.wdata = a ^ imm_i;
      OP_ANDI:         r.wdata = a & imm_i;
      OP_ADDIW:        r.wdata = sext32(a[31:0] + imm_i[31:0]);
      OP_SLLI:         r.wdata = a << i[25:20];
      OP_SRLI:         r.wdata = a >> i[25:20];
      OP_SRAI:         r.wdata = $signed(a) >>> i[25:20];
      OP_ADD:          r.wdata = a + b;
      OP_SUB:          r.wdata = a - b;
      OP_SLTU:         r.wdata = (a < b) ? 64'd1 : 64'd0;
      OP_OR:           r.wdata = a | b;
      OP_AND:          r.wdata = a & b;
      OP_ADDW:         r.wdata = sext32(a[31:0] + b[31:0]);
      OP_SLLW:         r.wdata = sext32(a[31:0] << b[4:0]);
      OP_MULW:         r.wdata = sext32(a[31:0] * b[31:0]);
      default:         r.wdata = '0;
    endcase
    r.we = !(r.op inside {OP_BNE, OP_BGE, OP_LW, OP_LBU, OP_LD, OP_SB, OP_SH, OP_SW, OP_SD,
                          OP_EBREAK, OP_ILLEGAL}) && (r.rd != 5'd0);
    case (r.op)
      OP_JAL:  r.next_pc = f.pc + imm_j;
      OP_JALR: r.next_pc = (a + imm_i) & ~64'd1;
      OP_BNE:  if (a != b) r.next_pc = f.pc + imm_b;
      OP_BGE:  if ($signed(a) >= $signed(b)) r.next_pc = f.pc + imm_b;
      default: r.next_pc = f.pc + 64'd4;
    endcase
    r.mem.valid = r.op inside {OP_LW, OP_LBU, OP_LD, OP_SB, OP_SH, OP_SW, OP_SD};
    r.mem.write = r.op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    r.mem.addr = r.mem.write ? (a + imm_s) : (a + imm_i);
    r.mem.wdata = b;
    r.mem.unsigned_load = (r.op == OP_LBU);
    case (r.op)
      OP_SH:        r.mem.size = 2'd1;
      OP_LW, OP_SW: r.mem.size = 2'd2;
      OP_LD, OP_SD: r.mem.size = 2'd3;
      default:      r.mem.size = 2'd0;   // byte accesses
    endcase
    r.ebreak = (r.op == OP_EBREAK);
    r.illegal = (r.op == OP_ILLEGAL);
    if (r.we) shadow_regs[r.rd] = r.wdata;
    return r;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [4:0] rnd_reg();
    logic [31:0] v;
    v = $random(seed);
    return 5'd1 + v % 31;   // x1..x31
  endfunction

  function automatic logic [31:0] rand_imm_op(input logic [4:0] rd, input logic [4:0] rs1);
    logic [31:0] r;
    logic [31:0] sel;
    r = $random(seed);
    sel = $random(seed);
    case (sel % 10)
      0:       return enc_u(r[19:0], rd, MAJ_LUI);
      1:       return enc_u(r[19:0], rd, MAJ_AUIPC);
      2:       return enc_i(r[11:0], rs1, 3'b000, rd, MAJ_OP_IMM);
      3:       return enc_i(r[11:0], rs1, 3'b011, rd, MAJ_OP_IMM);
      4:       return enc_i(r[11:0], rs1, 3'b100, rd, MAJ_OP_IMM);
      5:       return enc_i(r[11:0], rs1, 3'b111, rd, MAJ_OP_IMM);
      6:       return enc_i({6'b000000, r[5:0]}, rs1, 3'b001, rd, MAJ_OP_IMM);
      7:       return enc_i({6'b000000, r[5:0]}, rs1, 3'b101, rd, MAJ_OP_IMM);
      8:       return enc_i({6'b010000, r[5:0]}, rs1, 3'b101, rd, MAJ_OP_IMM);
      default: return enc_i(r[11:0], rs1, 3'b000, rd, MAJ_OP_IMM_32);
    endcase
  endfunction

  function automatic logic [31:0] rand_rr_op(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    logic [31:0] sel;
    sel = $random(seed);
    case (sel % 8)
      0:       return enc_r(7'b0000000, rs2, rs1, 3'b000, rd, MAJ_OP);
      1:       return enc_r(7'b0100000, rs2, rs1, 3'b000, rd, MAJ_OP);
      2:       return enc_r(7'b0000000, rs2, rs1, 3'b011, rd, MAJ_OP);
      3:       return enc_r(7'b0000000, rs2, rs1, 3'b110, rd, MAJ_OP);
      4:       return enc_r(7'b0000000, rs2, rs1, 3'b111, rd, MAJ_OP);
      5:       return enc_r(7'b0000000, rs2, rs1, 3'b000, rd, MAJ_OP_32);
      6:       return enc_r(7'b0000000, rs2, rs1, 3'b001, rd, MAJ_OP_32);
      default: return enc_r(7'b0000001, rs2, rs1, 3'b000, rd, MAJ_OP_32);   // mulw
    endcase
  endfunction

  function automatic logic [31:0] rand_ctrl_op();
    logic [31:0] r;
    logic [31:0] sel;
    r = $random(seed);
    sel = $random(seed);
    case (sel % 4)
      0:       return enc_j(r[20:0], rnd_reg());
      1:       return enc_i(r[11:0], rnd_reg(), 3'b000, rnd_reg(), MAJ_JALR);
      2:       return enc_b(r[12:0], rnd_reg(), rnd_reg(), 3'b001);
      default: return enc_b(r[12:0], rnd_reg(), rnd_reg(), 3'b101);
    endcase
  endfunction

  function automatic logic [31:0] rand_mem_op();
    logic [31:0] r;
    logic [31:0] sel;
    r = $random(seed);
    sel = $random(seed);
    case (sel % 7)
      0:       return enc_i(r[11:0], rnd_reg(), 3'b010, rnd_reg(), MAJ_LOAD);
      1:       return enc_i(r[11:0], rnd_reg(), 3'b100, rnd_reg(), MAJ_LOAD);
      2:       return enc_i(r[11:0], rnd_reg(), 3'b011, rnd_reg(), MAJ_LOAD);
      3:       return enc_s(r[11:0], rnd_reg(), rnd_reg(), 3'b000);
      4:       return enc_s(r[11:0], rnd_reg(), rnd_reg(), 3'b001);
      5:       return enc_s(r[11:0], rnd_reg(), rnd_reg(), 3'b010);
      default: return enc_s(r[11:0], rnd_reg(), rnd_reg(), 3'b011);
    endcase
  endfunction

  // drives one fetch strobe and queues its expected record and due cycle
  task automatic issue(input logic [31:0] inst);
    fetch_t f;
    f.pc = pc_cnt;
    f.inst = inst;
    @(posedge clk);
    #1;
    fetch_valid = 1'b1;
    fetch = f;
    exp_q.push_back(model_retire(f));
    due_q.push_back(cycle + 2);
    pc_cnt = pc_cnt + 64'd4;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      fetch_valid = 1'b0;
    end
  endtask

  task automatic drain();
    int n;
    idle(1);
    n = 0;
    while ((exp_q.size() != 0) && (n < 10)) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0)
      abort_run($sformatf("%0d retires never arrived in test %s", exp_q.size(), test_name));
  endtask

  // compare process samples at the falling edge where retire is stable
  always @(negedge clk) begin
    if (reset !== 1'b0) begin
      if (retire_valid === 1'b1) abort_run("retire_valid went high during reset");
    end else if (retire_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("retire_valid went high with no instruction in flight");
      end else begin
        exp_ret = exp_q.pop_front();
        exp_due = due_q.pop_front();
        if (cycle != exp_due) report_mismatch(test_name, "retire cycle", exp_due, cycle);
        check_retire(test_name, exp_ret, retire);
      end
    end else if (retire_valid !== 1'b0) begin
      abort_run("retire_valid is unknown after reset");
    end else if ((exp_q.size() != 0) && (cycle > due_q[0])) begin
      exp_ret = exp_q[0];
      abort_run($sformatf("retire for pc %h in test %s never arrived", exp_ret.pc, test_name));
    end
  end

  initial begin
    seed = 32'heb33;
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch = '0;
    pc_cnt = 64'h0000_0000_8000_0000;
    test_name = "reset";
    for (k = 0; k < 32; k++) shadow_regs[k] = 64'h0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    idle(6);   // no fetches, so no retires

    test_name = "regs_zero_after_reset";
    for (k = 0; k < 6; k++) issue(rand_rr_op(rnd_reg(), rnd_reg(), rnd_reg()));
    drain();

    test_name = "imm_ops";
    for (k = 1; k < 32; k++) begin
      word = $random(seed);
      issue(enc_u(word[31:12], k[4:0], MAJ_LUI));
      issue(enc_i(word[11:0], k[4:0], 3'b000, k[4:0], MAJ_OP_IMM));
    end
    for (k = 0; k < 60; k++) issue(rand_imm_op(rnd_reg(), rnd_reg()));
    drain();

    test_name = "reg_reg_chain";
    prev_rd = rnd_reg();
    for (k = 0; k < 40; k++) begin
      next_rd = rnd_reg();
      issue(rand_rr_op(next_rd, prev_rd, rnd_reg()));   // depends on the one before
      prev_rd = next_rd;
    end
    drain();

    test_name = "control_flow";
    issue(enc_i(12'hffb, 5'd0, 3'b000, 5'd5, MAJ_OP_IMM));   // x5 = -5
    issue(enc_i(12'h003, 5'd0, 3'b000, 5'd6, MAJ_OP_IMM));   // x6 = 3
    issue(enc_b(13'h0010, 5'd6, 5'd5, 3'b101));   // bge not taken
    issue(enc_b(13'h1ff0, 5'd5, 5'd6, 3'b101));   // bge taken backward
    issue(enc_b(13'h0008, 5'd5, 5'd5, 3'b101));
    issue(enc_b(13'h0020, 5'd5, 5'd5, 3'b001));   // bne not taken
    issue(enc_b(13'h0100, 5'd6, 5'd5, 3'b001));
    issue(enc_j(21'h1ffff0, 5'd1));
    issue(enc_j(21'h000800, 5'd0));
    issue(enc_i(12'h005, 5'd1, 3'b000, 5'd7, MAJ_JALR));   // odd target has bit 0 cleared
    for (k = 0; k < 24; k++) issue(rand_ctrl_op());
    drain();

    test_name = "loads_stores";
    for (k = 0; k < 35; k++) issue(rand_mem_op());
    drain();

    test_name = "special";
    issue(enc_i(12'h055, rnd_reg(), 3'b000, 5'd0, MAJ_OP_IMM));   // addi into x0
    issue(enc_u(20'habcde, 5'd0, MAJ_LUI));
    issue(enc_r(7'b0000000, 5'd0, 5'd0, 3'b110, 5'd9, MAJ_OP));   // or x9, x0, x0
    issue(`EBREAK_INST);
    issue(32'h0000_0073);   // ecall is not kept
    issue(enc_i(12'h123, rnd_reg(), 3'b111, rnd_reg(), MAJ_LOAD));
    for (k = 0; k < 8; k++) begin
      word = $random(seed);
      issue({word[31:7], 7'b0001011});   // custom-0 opcode
    end
    drain();

    test_name = "idle_tail";
    idle(8);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* source/rv_core_slice.sv */
// top level joining decode, register file, alu and execute stage
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core_slice
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    fetch_valid,
  input  fetch_t  fetch,
  output logic    retire_valid,
  output retire_t retire
);

  logic                  dec_valid;
  dec_t                  dec;
  logic [`REG_IDX_W-1:0] rs1_idx;
  logic [`REG_IDX_W-1:0] rs2_idx;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;
  logic                  wr_en;
  logic [`REG_IDX_W-1:0] wr_addr;
  logic [`XLEN-1:0]      wr_data;
  op_t                   alu_op;
  logic [`XLEN-1:0]      alu_a;
  logic [`XLEN-1:0]      alu_b;
  logic [`XLEN-1:0]      alu_result;

  rv_decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .dec_valid   (dec_valid),
    .dec         (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  rv_alu u_alu (.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_result(alu_result));

  rv_exec_unit u_exec (
    .clk          (clk),
    .reset        (reset),
    .dec_valid    (dec_valid),
    .dec          (dec),
    .rs1          (rs1_idx),
    .rs2          (rs2_idx),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .alu_op       (alu_op),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .alu_result   (alu_result),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

/* source/rv_exec_unit.sv */
// operand select, branch compare, next pc, address generation and retire stage
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_exec_unit
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  dec_valid,
  input  dec_t                  dec,
  output logic [`REG_IDX_W-1:0] rs1,
  output logic [`REG_IDX_W-1:0] rs2,
  input  logic [`XLEN-1:0]      rs1_data,
  input  logic [`XLEN-1:0]      rs2_data,
  output logic                  wr_en,
  output logic [`REG_IDX_W-1:0] wr_addr,
  output logic [`XLEN-1:0]      wr_data,
  output op_t                   alu_op,
  output logic [`XLEN-1:0]      alu_a,
  output logic [`XLEN-1:0]      alu_b,
  input  logic [`XLEN-1:0]      alu_result,
  output logic                  retire_valid,
  output retire_t               retire
);

  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] pc_target;
  logic             taken;
  retire_t          retire_next;

  assign rs1      = dec.rs1;
  assign rs2      = dec.rs2;
  assign pc_plus4 = dec.pc + `XLEN'd4;
  assign pc_target = dec.pc + dec.imm;   // jal and branches

  assign alu_op = dec.op;
  assign alu_a  = (dec.op == OP_AUIPC) ? dec.pc : rs1_data;

  always_comb begin
    case (dec.op)
      OP_ADD, OP_SUB, OP_SLTU, OP_OR, OP_AND,
      OP_ADDW, OP_SLLW, OP_MULW: alu_b = rs2_data;
      OP_SLLI, OP_SRLI, OP_SRAI: alu_b = {{(`XLEN-6){1'b0}}, dec.shamt};
      default:                   alu_b = dec.imm;   // also load/store/jalr sums
    endcase
  end

  assign taken = ((dec.op == OP_BNE) && (rs1_data != rs2_data)) ||
                 ((dec.op == OP_BGE) && ($signed(rs1_data) >= $signed(rs2_data)));

  always_comb begin
    retire_next         = '0;
    retire_next.pc      = dec.pc;
    retire_next.op      = dec.op;
    retire_next.rd      = dec.rd;
    retire_next.we      = dec.writes_rd;
    retire_next.ebreak  = (dec.op == OP_EBREAK);
    retire_next.illegal = (dec.op == OP_ILLEGAL);
    case (dec.op)
      OP_LUI:         retire_next.wdata = dec.imm;
      OP_JAL, OP_JALR: retire_next.wdata = pc_plus4;   // link value
      default:        retire_next.wdata = alu_result;
    endcase
    if ((dec.op == OP_JAL) || taken) retire_next.next_pc = pc_target;
    else if (dec.op == OP_JALR)      retire_next.next_pc = {alu_result[`XLEN-1:1], 1'b0};
    else                             retire_next.next_pc = pc_plus4;
    case (dec.op)
      OP_LBU, OP_SB: retire_next.mem.size = 2'd0;
      OP_SH:         retire_next.mem.size = 2'd1;
      OP_LW, OP_SW:  retire_next.mem.size = 2'd2;
      default:       retire_next.mem.size = 2'd3;   // ld, sd
    endcase
    retire_next.mem.valid = dec.op inside {OP_LW, OP_LBU, OP_LD, OP_SB, OP_SH, OP_SW, OP_SD};
    retire_next.mem.write = dec.op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    retire_next.mem.unsigned_load = (dec.op == OP_LBU);
    retire_next.mem.addr  = retire_next.mem.valid ? alu_result : '0;
    retire_next.mem.wdata = retire_next.mem.write ? rs2_data : '0;
    if (!retire_next.mem.valid) retire_next.mem.size = 2'd0;
  end

  // register write lands on the same edge as the retire record
  assign wr_en   = dec_valid && dec.writes_rd;
  assign wr_addr = dec.rd;
  assign wr_data = retire_next.wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= dec_valid;
    end
    if (dec_valid) retire <= retire_next;
  end

endmodule

/* source/rv_alu.sv */
// 64-bit and word-width arithmetic, logic, shifts and mulw
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_alu
  import rv_isa_pkg::*;
(
  input  op_t              alu_op,
  input  logic [`XLEN-1:0] alu_a,
  input  logic [`XLEN-1:0] alu_b,
  output logic [`XLEN-1:0] alu_result
);

  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] diff;
  logic [5:0]       shamt64;
  logic [4:0]       shamt32;
  logic [31:0]      sum_w;
  logic [31:0]      sll_w;
  logic [31:0]      mul_w;

  assign sum     = alu_a + alu_b;
  assign diff    = alu_a - alu_b;
  assign shamt64 = alu_b[5:0];
  assign shamt32 = alu_b[4:0];   // sllw uses 5 bits

  assign sum_w   = alu_a[31:0] + alu_b[31:0];
  assign sll_w   = alu_a[31:0] << shamt32;
  assign mul_w   = alu_a[31:0] * alu_b[31:0];   // low half only

  always_comb begin
    case (alu_op)
      OP_SUB: begin
        alu_result = diff;
      end
      OP_SLTU, OP_SLTIU: begin
        alu_result = {{(`XLEN-1){1'b0}}, (alu_a < alu_b)};
      end
      OP_XORI: begin
        alu_result = alu_a ^ alu_b;
      end
      OP_OR: begin
        alu_result = alu_a | alu_b;
      end
      OP_AND, OP_ANDI: begin
        alu_result = alu_a & alu_b;
      end
      OP_SLLI: begin
        alu_result = alu_a << shamt64;
      end
      OP_SRLI: begin
        alu_result = alu_a >> shamt64;
      end
      OP_SRAI: begin
        alu_result = $signed(alu_a) >>> shamt64;
      end
      OP_ADDIW, OP_ADDW: begin
        alu_result = {{(`XLEN-32){sum_w[31]}}, sum_w};
      end
      OP_SLLW: begin
        alu_result = {{(`XLEN-32){sll_w[31]}}, sll_w};
      end
      OP_MULW: begin
        alu_result = {{(`XLEN-32){mul_w[31]}}, mul_w};
      end
      // add, addi, auipc, and address / jalr target sums
      default: begin
        alu_result = sum;
      end
    endcase
  end

endmodule

/* source/rv_regfile.sv */
// 32 by 64 register file with x0 tied to zero, two reads and one write
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`REG_IDX_W-1:0] rs1,
  input  logic [`REG_IDX_W-1:0] rs2,
  output logic [`XLEN-1:0]      rs1_data,
  output logic [`XLEN-1:0]      rs2_data,
  input  logic                  wr_en,
  input  logic [`REG_IDX_W-1:0] wr_addr,
  input  logic [`XLEN-1:0]      wr_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= `REG_RESET_VAL;
      end
    end else if (wr_en && (wr_addr != '0)) begin   // x0 ignores writes
      regs[wr_addr] <= wr_data;
    end
  end

  // reads are combinational, so a write at this edge is seen next cycle
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* source/rv_decode.sv */
// instruction decoder with immediate generation and registered decode stage
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_decode
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   fetch_valid,
  input  fetch_t fetch,
  output logic   dec_valid,
  output dec_t   dec
);

  logic [`INST_W-1:0] inst;
  major_t             major;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [5:0]         funct6;
  op_t                op;
  imm_fmt_t           fmt;
  logic [`XLEN-1:0]   imm;
  logic               writes_rd;
  dec_t               dec_next;

  assign inst   = fetch.inst;
  assign major  = major_t'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign funct6 = inst[31:26];   // rv64 shifts use a 6-bit shamt

  always_comb begin
    op  = OP_ILLEGAL;
    fmt = IMM_NONE;
    case (major)
      MAJ_LUI:   begin op = OP_LUI;   fmt = IMM_U; end
      MAJ_AUIPC: begin op = OP_AUIPC; fmt = IMM_U; end
      MAJ_JAL:   begin op = OP_JAL;   fmt = IMM_J; end
      MAJ_JALR: begin
        fmt = IMM_I;
        if (funct3 == 3'b000) op = OP_JALR;
      end
      MAJ_BRANCH: begin
        fmt = IMM_B;
        case (funct3)
          3'b001:  op = OP_BNE;
          3'b101:  op = OP_BGE;   // signed
          default: op = OP_ILLEGAL;
        endcase
      end
      MAJ_LOAD: begin
        fmt = IMM_I;
        case (funct3)
          3'b010:  op = OP_LW;
          3'b011:  op = OP_LD;
          3'b100:  op = OP_LBU;
          default: op = OP_ILLEGAL;
        endcase
      end
      MAJ_STORE: begin
        fmt = IMM_S;
        case (funct3)
          3'b000:  op = OP_SB;
          3'b001:  op = OP_SH;
          3'b010:  op = OP_SW;
          3'b011:  op = OP_SD;
          default: op = OP_ILLEGAL;
        endcase
      end
      MAJ_OP_IMM: begin
        fmt = IMM_I;
        case (funct3)
          3'b000:  op = OP_ADDI;
          3'b011:  op = OP_SLTIU;
          3'b100:  op = OP_XORI;
          3'b111:  op = OP_ANDI;
          3'b001:  op = (funct6 == 6'b000000) ? OP_SLLI : OP_ILLEGAL;
          3'b101: begin
            if (funct6 == 6'b000000)      op = OP_SRLI;
            else if (funct6 == 6'b010000) op = OP_SRAI;
          end
          default: op = OP_ILLEGAL;
        endcase
      end
      MAJ_OP_IMM_32: begin
        fmt = IMM_I;
        if (funct3 == 3'b000) op = OP_ADDIW;
      end
      MAJ_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: op = OP_ADD;
          10'b0100000_000: op = OP_SUB;
          10'b0000000_011: op = OP_SLTU;
          10'b0000000_110: op = OP_OR;
          10'b0000000_111: op = OP_AND;
          default:         op = OP_ILLEGAL;
        endcase
      end
      MAJ_OP_32: begin
        case ({funct7, funct3})
          10'b0000000_000: op = OP_ADDW;
          10'b0000000_001: op = OP_SLLW;
          10'b0000001_000: op = OP_MULW;
          default:         op = OP_ILLEGAL;
        endcase
      end
      MAJ_SYSTEM: if (inst == `EBREAK_INST) op = OP_EBREAK;
      default:    op = OP_ILLEGAL;
    endcase
  end

  always_comb begin
    case (fmt)
      IMM_I:   imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
      IMM_U:   imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
      IMM_J:   imm = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      IMM_B:   imm = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      IMM_S:   imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
      default: imm = '0;
    endcase
  end

  always_comb begin
    case (op)
      OP_BNE, OP_BGE, OP_LW, OP_LBU, OP_LD,
      OP_SB, OP_SH, OP_SW, OP_SD, OP_EBREAK, OP_ILLEGAL: writes_rd = 1'b0;
      default: writes_rd = (inst[11:7] != '0);   // x0 never written
    endcase
  end

  always_comb begin
    dec_next.pc        = fetch.pc;
    dec_next.op        = op;
    dec_next.rd        = inst[11:7];
    dec_next.rs1       = inst[19:15];
    dec_next.rs2       = inst[24:20];
    dec_next.shamt     = inst[25:20];
    dec_next.imm       = imm;
    dec_next.writes_rd = writes_rd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= fetch_valid;
    end
    if (fetch_valid) dec <= dec_next;   // payload only
  end

endmodule

/* source/rv_pipe_pkg.sv */
// packed records for fetch input, decoded instruction, memory request and retire
`include "rv_cfg.svh"

package rv_pipe_pkg;
  import rv_isa_pkg::*;

  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`INST_W-1:0] inst;
  } fetch_t;

  typedef struct packed {
    logic [`XLEN-1:0]      pc;
    op_t                   op;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [5:0]            shamt;      // inst[25:20]
    logic [`XLEN-1:0]      imm;        // sign-extended for its format
    logic                  writes_rd;  // cleared for rd == x0
  } dec_t;

  typedef struct packed {
    logic             valid;
    logic             write;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic [1:0]       size;           // log2 of byte count
    logic             unsigned_load;
  } mem_req_t;

  typedef struct packed {
    logic [`XLEN-1:0]      pc;
    op_t                   op;
    logic [`REG_IDX_W-1:0] rd;
    logic                  we;
    logic [`XLEN-1:0]      wdata;
    logic [`XLEN-1:0]      next_pc;
    mem_req_t              mem;
    logic                  ebreak;
    logic                  illegal;
  } retire_t;

endpackage

/* source/rv_isa_pkg.sv */
// isa enums for major opcode, decoded operation and immediate format
package rv_isa_pkg;

  // major opcode field, inst[6:0]
  typedef enum logic [6:0] {
    MAJ_LUI       = 7'b0110111,
    MAJ_AUIPC     = 7'b0010111,
    MAJ_JAL       = 7'b1101111,
    MAJ_JALR      = 7'b1100111,
    MAJ_BRANCH    = 7'b1100011,
    MAJ_LOAD      = 7'b0000011,
    MAJ_STORE     = 7'b0100011,
    MAJ_OP_IMM    = 7'b0010011,
    MAJ_OP_IMM_32 = 7'b0011011,
    MAJ_OP        = 7'b0110011,
    MAJ_OP_32     = 7'b0111011,
    MAJ_SYSTEM    = 7'b1110011
  } major_t;

  // one value per recognized instruction
  typedef enum logic [4:0] {
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BNE,
    OP_BGE,
    OP_LW,
    OP_LBU,
    OP_LD,
    OP_SB,
    OP_SH,
    OP_SW,
    OP_SD,
    OP_ADDI,
    OP_SLTIU,
    OP_XORI,
    OP_ANDI,
    OP_ADDIW,
    OP_SLLI,
    OP_SRLI,
    OP_SRAI,
    OP_ADD,
    OP_SUB,
    OP_SLTU,
    OP_OR,
    OP_AND,
    OP_ADDW,
    OP_SLLW,
    OP_MULW,
    OP_EBREAK,
    OP_ILLEGAL
  } op_t;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_U,
    IMM_J,
    IMM_B,
    IMM_S,
    IMM_NONE   // r-type and system
  } imm_fmt_t;

endpackage

/* include/rv_cfg.svh */
// defines for data width, register file size, reset value and the ebreak encoding
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define XLEN          64            // rv64 data width
`define INST_W        32            // base instruction width

`define REG_COUNT     32            // x0..x31
`define REG_IDX_W     5             // bits in a register index
`define REG_RESET_VAL 64'h0         // every register after reset

`define EBREAK_INST   32'h00100073  // whole-word match

`endif
